// ==== hdl/dec_params.svh ====
// widths, depths and exception codes of the decode unit, included by every rtl and bench file
`ifndef DEC_PARAMS_SVH
`define DEC_PARAMS_SVH

//**********************************************************************
// datapath
//**********************************************************************
`define DEC_XLEN         32   // integer register and result width
`define DEC_NUM_GPR      32   // architectural registers, x0 included
`define DEC_REG_W        5    // register address bits

//**********************************************************************
// buffering and exceptions
//**********************************************************************
`define DEC_IB_DEPTH     2    // instruction buffer entries
`define DEC_EXC_ILLEGAL  2    // mcause code, illegal instruction

`endif

// ==== hdl/dec_pkg.sv ====
// shared packet types of the decode unit, imported by wildcard in every module header
`default_nettype none

`include "dec_params.svh"

package dec_pkg;

   //**********************************************************************
   // fetch side
   //**********************************************************************

   typedef struct packed {
      logic [`DEC_XLEN-1:0] instr;      // 32b instruction word
      logic [`DEC_XLEN-1:1] pc;         // halfword pc, bit 0 implied
   } fetch_pkt_t;

   //**********************************************************************
   // execute side, one-hot op select
   //**********************************************************************

   typedef struct packed {
      logic add;
      logic sub;
      logic slt;                        // signed compare
      logic sltu;                       // unsigned compare
      logic land;
      logic lor;
      logic lxor;
      logic sll;
      logic srl;
      logic sra;
      logic lui;                        // pass immediate through
      logic imm;                        // operand b from immediate, not rs2
   } alu_pkt_t;

   //**********************************************************************
   // pipe bookkeeping e1 .. wb
   //**********************************************************************

   typedef struct packed {
      logic                  valid;     // stage holds an instruction
      logic [`DEC_REG_W-1:0] rd;        // destination
      logic                  wen;       // writes rd, never x0
      logic                  illegal;   // outside the decoded subset
      logic [`DEC_XLEN-1:0]  instr;
      logic [`DEC_XLEN-1:1]  pc;
   } dest_pkt_t;

   //**********************************************************************
   // retire report at wb1
   //**********************************************************************

   typedef struct packed {
      logic                 trace_rv_i_valid_ip;      // retired or excepted
      logic                 trace_rv_i_exception_ip;  // illegal instruction
      logic [4:0]           trace_rv_i_ecause_ip;     // cause, 0 on normal retire
      logic [`DEC_XLEN-1:0] trace_rv_i_insn_ip;
      logic [`DEC_XLEN-1:0] trace_rv_i_address_ip;    // byte address
   } trace_pkt_t;

endpackage

`default_nettype wire

// ==== hdl/dec_ib_ctl.sv ====
// instruction buffer between fetch and decode, instantiated once by the decode top level
`default_nettype none
`timescale 1ns/100ps

`include "dec_params.svh"

module dec_ib_ctl
   import dec_pkg::*;
(
   input  logic       clk,
   input  logic       reset,

   input  logic       ifu_i0_valid,      // fetch offers an instruction
   input  fetch_pkt_t ifu_i0_pkt,
   output logic       ifu_i0_ready,      // room for one more

   output logic       ib0_valid,         // head entry valid
   output fetch_pkt_t ib0_pkt,           // oldest instruction

   input  logic       dec_i0_decode_d    // head consumed this cycle
);

   localparam int DEPTH = `DEC_IB_DEPTH;
   localparam int CNT_W = $clog2(DEPTH + 1);

   fetch_pkt_t       ib_q     [DEPTH];   // entry 0 is the oldest
   fetch_pkt_t       ib_shift [DEPTH];   // what each entry takes on a pop
   logic [CNT_W-1:0] ib_cnt;             // occupied entries
   logic [CNT_W-1:0] wr_idx;             // slot for the incoming fetch
   logic             push;
   logic             pop;

   assign ifu_i0_ready = (ib_cnt != CNT_W'(DEPTH)); // low only when full
   assign push         = ifu_i0_valid & ifu_i0_ready;
   assign pop          = dec_i0_decode_d & ib0_valid;
   assign wr_idx       = ib_cnt - CNT_W'(pop);       // lands below a departing head

   assign ib0_valid    = (ib_cnt != '0);
   assign ib0_pkt      = ib_q[0];

   // each entry shifts down from the next, last one holds
   for (genvar i = 0; i < DEPTH; i++) begin : g_shift
      if (i < DEPTH - 1) begin : g_mid
         assign ib_shift[i] = ib_q[i+1];
      end else begin : g_last
         assign ib_shift[i] = ib_q[i];
      end
   end

   //**********************************************************************
   // occupancy
   //**********************************************************************

   always_ff @(posedge clk) begin
      if (reset) begin
         ib_cnt <= '0;
      end else begin
         ib_cnt <= ib_cnt + CNT_W'(push) - CNT_W'(pop);
      end
   end

   // entry payload, order kept by shifting toward 0
   always_ff @(posedge clk) begin
      for (int i = 0; i < DEPTH; i++) begin
         if (push && (wr_idx == CNT_W'(i))) begin
            ib_q[i] <= ifu_i0_pkt;       // new fetch behind the survivors
         end else if (pop) begin
            ib_q[i] <= ib_shift[i];      // advance one place
         end
      end
   end

endmodule

`default_nettype wire

// ==== hdl/dec_decode_ctl.sv ====
// slot 0 decoder with raw scoreboard and e1 to wb pipe, instantiated by the decode top level
`default_nettype none
`timescale 1ns/100ps

`include "dec_params.svh"

module dec_decode_ctl
   import dec_pkg::*;
(
   input  logic                  clk,
   input  logic                  reset,

   input  logic                  ib0_valid,          // buffer head valid
   input  fetch_pkt_t            ib0_pkt,

   output logic                  dec_i0_decode_d,    // head issues, pops buffer
   output alu_pkt_t              i0_ap,              // alu op to execute
   output logic [`DEC_XLEN-1:0]  dec_i0_immed_d,
   output logic [`DEC_REG_W-1:0] dec_i0_rs1_d,       // gpr read addresses
   output logic [`DEC_REG_W-1:0] dec_i0_rs2_d,
   output logic                  dec_i0_rs1_en_d,
   output logic                  dec_i0_rs2_en_d,
   output logic [`DEC_XLEN-1:1]  dec_i0_pc_d,

   output logic                  dec_tlu_i0_valid_e4,
   output logic [`DEC_XLEN-1:1]  dec_tlu_i0_pc_e4,
   input  logic [`DEC_XLEN-1:0]  exu_i0_result_e4,   // alu result, same cycle as e4

   output logic [`DEC_REG_W-1:0] dec_i0_waddr_wb,    // gpr write port
   output logic                  dec_i0_wen_wb,
   output logic [`DEC_XLEN-1:0]  dec_i0_wdata_wb,
   output dest_pkt_t             dec_i0_wb_pkt       // to trace
);

   localparam logic [6:0] OPC_OP     = 7'b0110011;
   localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
   localparam logic [6:0] OPC_LUI    = 7'b0110111;
   localparam logic [6:0] F7_BASE    = 7'b0000000;
   localparam logic [6:0] F7_ALT     = 7'b0100000;   // sub, sra
   localparam int         E4         = 4;
   localparam int         WB         = 5;

   logic [`DEC_XLEN-1:0]  instr;
   logic [6:0]            opcode;
   logic [2:0]            funct3;
   logic [6:0]            funct7;
   logic [`DEC_REG_W-1:0] rd;
   logic                  legal;
   logic                  sb_stall;
   dest_pkt_t             d_pkt;
   dest_pkt_t             pipe_q [1:WB];             // e1 .. e4, wb

   // source hits a pending write
   function automatic logic raw_hit(input dest_pkt_t             p,
                                    input logic [`DEC_REG_W-1:0] rs,
                                    input logic                  rs_en);
      raw_hit = p.valid & p.wen & rs_en & (rs != '0) & (p.rd == rs);
   endfunction

   assign instr        = ib0_pkt.instr;
   assign opcode       = instr[6:0];
   assign funct3       = instr[14:12];
   assign funct7       = instr[31:25];
   assign rd           = instr[11:7];
   assign dec_i0_rs1_d = instr[19:15];
   assign dec_i0_rs2_d = instr[24:20];
   assign dec_i0_pc_d  = ib0_pkt.pc;

   //**********************************************************************
   // decode, rv32i alu subset plus lui
   //**********************************************************************

   always_comb begin
      i0_ap           = '0;
      dec_i0_rs1_en_d = 1'b0;
      dec_i0_rs2_en_d = 1'b0;
      dec_i0_immed_d  = '0;
      case (opcode)
         OPC_OP: begin
            case ({funct7, funct3})
               {F7_BASE, 3'b000}: i0_ap.add  = 1'b1;
               {F7_ALT,  3'b000}: i0_ap.sub  = 1'b1;
               {F7_BASE, 3'b001}: i0_ap.sll  = 1'b1;
               {F7_BASE, 3'b010}: i0_ap.slt  = 1'b1;
               {F7_BASE, 3'b011}: i0_ap.sltu = 1'b1;
               {F7_BASE, 3'b100}: i0_ap.lxor = 1'b1;
               {F7_BASE, 3'b101}: i0_ap.srl  = 1'b1;
               {F7_ALT,  3'b101}: i0_ap.sra  = 1'b1;
               {F7_BASE, 3'b110}: i0_ap.lor  = 1'b1;
               {F7_BASE, 3'b111}: i0_ap.land = 1'b1;
               default:           i0_ap      = '0;    // bad funct7
            endcase
            dec_i0_rs1_en_d = 1'b1;
            dec_i0_rs2_en_d = 1'b1;
         end
         OPC_OP_IMM: begin
            case (funct3)
               3'b000:  i0_ap.add  = 1'b1;
               3'b001:  i0_ap.sll  = (funct7 == F7_BASE);
               3'b010:  i0_ap.slt  = 1'b1;
               3'b011:  i0_ap.sltu = 1'b1;
               3'b100:  i0_ap.lxor = 1'b1;
               3'b101: begin
                  i0_ap.srl = (funct7 == F7_BASE);
                  i0_ap.sra = (funct7 == F7_ALT);
               end
               3'b110:  i0_ap.lor  = 1'b1;
               default: i0_ap.land = 1'b1;           // andi
            endcase
            i0_ap.imm       = 1'b1;
            dec_i0_rs1_en_d = 1'b1;
            dec_i0_immed_d  = {{(`DEC_XLEN-12){instr[31]}}, instr[31:20]}; // i-type
         end
         OPC_LUI: begin
            i0_ap.lui      = 1'b1;
            i0_ap.imm      = 1'b1;
            dec_i0_immed_d = {instr[31:12], 12'b0};  // u-type
         end
         default: i0_ap = '0;
      endcase
      legal = i0_ap.add | i0_ap.sub | i0_ap.slt | i0_ap.sltu | i0_ap.land | i0_ap.lor |
              i0_ap.lxor | i0_ap.sll | i0_ap.srl | i0_ap.sra | i0_ap.lui;
      if (!legal) begin                               // no reads, no op
         i0_ap           = '0;
         dec_i0_rs1_en_d = 1'b0;
         dec_i0_rs2_en_d = 1'b0;
         dec_i0_immed_d  = '0;
      end
   end

   //**********************************************************************
   // scoreboard, stall on raw against e1 .. e4
   //**********************************************************************

   always_comb begin
      sb_stall = 1'b0;
      for (int i = 1; i <= E4; i++) begin
         sb_stall |= raw_hit(pipe_q[i], dec_i0_rs1_d, dec_i0_rs1_en_d) |
                     raw_hit(pipe_q[i], dec_i0_rs2_d, dec_i0_rs2_en_d);
      end
   end

   assign dec_i0_decode_d = ib0_valid & ~sb_stall;

   always_comb begin
      d_pkt.valid   = dec_i0_decode_d;               // bubble on stall
      d_pkt.rd      = rd;
      d_pkt.wen     = legal & (rd != '0);            // x0 write dropped here
      d_pkt.illegal = ~legal;
      d_pkt.instr   = instr;
      d_pkt.pc      = ib0_pkt.pc;
   end

   //**********************************************************************
   // e1 .. wb stage registers
   //**********************************************************************

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 1; i <= WB; i++) begin
            pipe_q[i] <= '0;
         end
      end else begin
         pipe_q[1] <= d_pkt;
         for (int i = 2; i <= WB; i++) begin
            pipe_q[i] <= pipe_q[i-1];
         end
      end
   end

   always_ff @(posedge clk) begin
      dec_i0_wdata_wb <= exu_i0_result_e4;           // result rides along into wb
   end

   // every decoded instruction shows at e4, illegal ones too
   assign dec_tlu_i0_valid_e4 = pipe_q[E4].valid;
   assign dec_tlu_i0_pc_e4    = pipe_q[E4].pc;

   assign dec_i0_waddr_wb     = pipe_q[WB].rd;
   assign dec_i0_wen_wb       = pipe_q[WB].valid & pipe_q[WB].wen;
   assign dec_i0_wb_pkt       = pipe_q[WB];

endmodule

`default_nettype wire

// ==== hdl/dec_gpr_ctl.sv ====
// integer register file with two read ports and one write port, instantiated by the decode top
`default_nettype none
`timescale 1ns/100ps

`include "dec_params.svh"

module dec_gpr_ctl
   import dec_pkg::*;
(
   input  logic                  clk,
   input  logic                  reset,

   input  logic [`DEC_REG_W-1:0] raddr0,     // rs1
   input  logic                  rden0,
   input  logic [`DEC_REG_W-1:0] raddr1,     // rs2
   input  logic                  rden1,

   input  logic [`DEC_REG_W-1:0] waddr0,     // wb write
   input  logic                  wen0,
   input  logic [`DEC_XLEN-1:0]  wd0,

   output logic [`DEC_XLEN-1:0]  rd0,
   output logic [`DEC_XLEN-1:0]  rd1
);

   logic [`DEC_XLEN-1:0] gpr_q [1:`DEC_NUM_GPR-1];   // x0 has no storage

   // one read port, write-through from wb
   function automatic logic [`DEC_XLEN-1:0] gpr_read(input logic [`DEC_REG_W-1:0] addr,
                                                      input logic                  en);
      gpr_read = '0;                                 // disabled or x0
      if (en && (addr != '0)) begin
         gpr_read = (wen0 && (waddr0 == addr)) ? wd0 : gpr_q[addr];
      end
   endfunction

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 1; i < `DEC_NUM_GPR; i++) begin
            gpr_q[i] <= '0;                          // all read zero after reset
         end
      end else if (wen0 && (waddr0 != '0)) begin
         gpr_q[waddr0] <= wd0;
      end
   end

   always_comb begin
      rd0 = gpr_read(raddr0, rden0);
      rd1 = gpr_read(raddr1, rden1);
   end

endmodule

`default_nettype wire

// ==== hdl/dec_trace.sv ====
// wb1 staging and retire trace packet assembly, instantiated by the decode top level
`default_nettype none
`timescale 1ns/100ps

`include "dec_params.svh"

module dec_trace
   import dec_pkg::*;
(
   input  logic       clk,
   input  logic       reset,

   input  dest_pkt_t  dec_i0_wb_pkt,        // instruction leaving wb
   output trace_pkt_t trace_rv_trace_pkt    // one report per instruction
);

   dest_pkt_t wb1_q;
   logic      exc_wb1;

   // one stage past wb
   always_ff @(posedge clk) begin
      if (reset) begin
         wb1_q <= '0;
      end else begin
         wb1_q <= dec_i0_wb_pkt;
      end
   end

   assign exc_wb1 = wb1_q.valid & wb1_q.illegal;  // only exception source here

   //**********************************************************************
   // packet fields
   //**********************************************************************

   assign trace_rv_trace_pkt.trace_rv_i_valid_ip     = wb1_q.valid;
   assign trace_rv_trace_pkt.trace_rv_i_exception_ip = exc_wb1;
   assign trace_rv_trace_pkt.trace_rv_i_ecause_ip    = exc_wb1 ? 5'(`DEC_EXC_ILLEGAL) : 5'd0;
   assign trace_rv_trace_pkt.trace_rv_i_insn_ip      = wb1_q.instr;
   assign trace_rv_trace_pkt.trace_rv_i_address_ip   = {wb1_q.pc, 1'b0}; // back to bytes

endmodule

`default_nettype wire

// ==== hdl/dec.sv ====
// decode unit top level, wires the buffer, decoder, register file and trace for the core
`default_nettype none
`timescale 1ns/100ps

`include "dec_params.svh"

module dec
   import dec_pkg::*;
(
   input  logic                 clk,
   input  logic                 reset,

   input  logic                 ifu_i0_valid,         // fetch handshake
   input  fetch_pkt_t           ifu_i0_pkt,
   output logic                 ifu_i0_ready,

   output logic                 dec_i0_decode_d,      // qualifies the d outputs
   output alu_pkt_t             i0_ap,
   output logic [`DEC_XLEN-1:0] dec_i0_immed_d,
   output logic [`DEC_XLEN-1:0] gpr_i0_rs1_d,         // operands from the arf
   output logic [`DEC_XLEN-1:0] gpr_i0_rs2_d,
   output logic [`DEC_XLEN-1:1] dec_i0_pc_d,

   output logic                 dec_tlu_i0_valid_e4,
   output logic [`DEC_XLEN-1:1] dec_tlu_i0_pc_e4,
   input  logic [`DEC_XLEN-1:0] exu_i0_result_e4,

   output trace_pkt_t           trace_rv_trace_pkt
);

   // buffer head
   logic                  ib0_valid;
   fetch_pkt_t            ib0_pkt;

   // gpr reads at d
   logic [`DEC_REG_W-1:0] dec_i0_rs1_d;
   logic [`DEC_REG_W-1:0] dec_i0_rs2_d;
   logic                  dec_i0_rs1_en_d;
   logic                  dec_i0_rs2_en_d;

   // gpr write at wb
   logic [`DEC_REG_W-1:0] dec_i0_waddr_wb;
   logic                  dec_i0_wen_wb;
   logic [`DEC_XLEN-1:0]  dec_i0_wdata_wb;
   dest_pkt_t             dec_i0_wb_pkt;

   dec_ib_ctl instbuff (.*);

   dec_decode_ctl decode (.*);

   dec_gpr_ctl arf (.*,
                    .raddr0(dec_i0_rs1_d),    .rden0(dec_i0_rs1_en_d),
                    .raddr1(dec_i0_rs2_d),    .rden1(dec_i0_rs2_en_d),
                    .waddr0(dec_i0_waddr_wb), .wen0(dec_i0_wen_wb),
                    .wd0(dec_i0_wdata_wb),
                    .rd0(gpr_i0_rs1_d),       .rd1(gpr_i0_rs2_d));

   dec_trace trace (.*);

endmodule

`default_nettype wire

// ==== bench/dec_tb.sv ====
// testbench for the decode unit that feeds random rv32i alu code and checks decode, e4 and trace
`default_nettype none
`timescale 1ns/100ps

`include "dec_params.svh"

module dec_tb
   import dec_pkg::*;
();

   localparam int          NUM_INSTR      = 400;
   localparam int          RESET_CYCLES   = 10;
   localparam int          TIMEOUT_CYCLES = NUM_INSTR * 10 + RESET_CYCLES;
   localparam logic [31:0] LFSR_SEED      = 32'h7494_572b;
   localparam logic [31:0] PC_START       = 32'h0000_1000;

   typedef struct packed {
      logic [31:0] instr;
      logic [31:0] pc;                  // byte address
      alu_pkt_t    ap;                  // expected decode
      logic [31:0] imm;
      logic        legal;
      logic        use_rs1;
      logic        use_rs2;
      logic [4:0]  rd;
      logic [4:0]  rs1;
      logic [4:0]  rs2;
   } ref_instr_t;

   typedef struct packed {
      logic [31:0] pc;
      logic [31:0] result;              // what the execute model returns at e4
   } e4_exp_t;

   logic                 clk;
   logic                 reset;
   logic                 ifu_i0_valid;
   fetch_pkt_t           ifu_i0_pkt;
   logic                 ifu_i0_ready;
   logic                 dec_i0_decode_d;
   alu_pkt_t             i0_ap;
   logic [`DEC_XLEN-1:0] dec_i0_immed_d;
   logic [`DEC_XLEN-1:0] gpr_i0_rs1_d;
   logic [`DEC_XLEN-1:0] gpr_i0_rs2_d;
   logic [`DEC_XLEN-1:1] dec_i0_pc_d;
   logic                 dec_tlu_i0_valid_e4;
   logic [`DEC_XLEN-1:1] dec_tlu_i0_pc_e4;
   logic [`DEC_XLEN-1:0] exu_i0_result_e4;
   trace_pkt_t           trace_rv_trace_pkt;

   logic [31:0] lfsr_state;
   logic [31:0] gpr_model [32];         // architectural state in program order
   ref_instr_t  offer;                  // instruction on the fetch port
   logic [31:0] next_pc;
   logic        accepted;               // offer taken at the coming edge
   int          sent;
   int          retired;
   int          cycle_cnt;
   ref_instr_t  decode_q [$];           // fetched but not yet decoded
   e4_exp_t     e4_q     [$];           // decoded but not yet at e4
   ref_instr_t  trace_q  [$];           // decoded but not yet traced

   dec dut (.*);

   always #10 clk = ~clk;

   //**********************************************************************
   // error reporting and random bits
   //**********************************************************************

   task automatic stop_on_error(input string msg);
      $display("%s", msg);
      $display("Done: errors found");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic report_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
      stop_on_error($sformatf("CHECK FAILED at time %0t: %s is %h, expected %h",
                              $time, name, got, exp));
   endtask

   // x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      lfsr_next = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_next(lfsr_state);   // one step per bit
         v          = {v[30:0], lfsr_state[0]};
      end
      take_bits = v;
   endfunction

   //**********************************************************************
   // instruction model with isa decode and alu
   //**********************************************************************

   function automatic alu_pkt_t op_flags(input logic [2:0] f3, input logic alt);
      alu_pkt_t ap;
      ap = '0;
      case (f3)
         3'b000: begin
            ap.add = ~alt;
            ap.sub = alt;
         end
         3'b001: ap.sll  = 1'b1;
         3'b010: ap.slt  = 1'b1;
         3'b011: ap.sltu = 1'b1;
         3'b100: ap.lxor = 1'b1;
         3'b101: begin
            ap.srl = ~alt;
            ap.sra = alt;
         end
         3'b110: ap.lor  = 1'b1;
         default: ap.land = 1'b1;
      endcase
      op_flags = ap;
   endfunction

   function automatic logic [31:0] alu_model(input alu_pkt_t ap, input logic [31:0] a,
                                             input logic [31:0] rs2v, input logic [31:0] imm);
      logic [31:0] b;
      b = ap.imm ? imm : rs2v;               // immediate forms take operand b from imm
      case (1'b1)
         ap.add:  alu_model = a + b;
         ap.sub:  alu_model = a - b;
         ap.slt:  alu_model = {31'b0, $signed(a) < $signed(b)};
         ap.sltu: alu_model = {31'b0, a < b};
         ap.land: alu_model = a & b;
         ap.lor:  alu_model = a | b;
         ap.lxor: alu_model = a ^ b;
         ap.sll:  alu_model = a << b[4:0];
         ap.srl:  alu_model = a >> b[4:0];
         ap.sra:  alu_model = $signed(a) >>> b[4:0];
         ap.lui:  alu_model = imm;
         default: alu_model = '0;
      endcase
   endfunction

   task automatic build_instr(output ref_instr_t r);
      logic [2:0]  f3;
      logic [1:0]  form;
      logic [11:0] imm12;
      logic [19:0] imm20;
      logic        flip;
      logic        alt;
      r       = '0;
      r.pc    = next_pc;
      next_pc = next_pc + 32'd4;
      r.rd    = 5'(take_bits(3));            // x0..x7 so hazards come often
      r.rs1   = 5'(take_bits(3));
      r.rs2   = 5'(take_bits(3));
      f3      = 3'(take_bits(3));
      flip    = (take_bits(1) != 0);
      form    = 2'(take_bits(2));
      if (take_bits(4) == 32'd0) begin       // about 1 in 16 illegal
         r.instr = {20'(take_bits(20)), r.rd, flip ? 7'b0000011 : 7'b1100011}; // load or branch
      end else if (form == 2'd3) begin
         imm20    = 20'(take_bits(20));
         r.instr  = {imm20, r.rd, 7'b0110111};
         r.ap.lui = 1'b1;
         r.ap.imm = 1'b1;
         r.imm    = {imm20, 12'b0};
         r.legal  = 1'b1;
      end else if (form == 2'd2) begin
         alt   = (f3 == 3'b101) && flip;     // srai
         imm12 = 12'(take_bits(12));
         if ((f3 == 3'b001) || (f3 == 3'b101)) begin
            imm12 = {alt ? 7'h20 : 7'h00, imm12[4:0]}; // shamt only
         end
         r.instr   = {imm12, r.rs1, f3, r.rd, 7'b0010011};
         r.ap      = op_flags(f3, alt);
         r.ap.imm  = 1'b1;
         r.imm     = {{20{imm12[11]}}, imm12};
         r.legal   = 1'b1;
         r.use_rs1 = 1'b1;
      end else begin
         alt       = ((f3 == 3'b000) || (f3 == 3'b101)) && flip; // sub, sra
         r.instr   = {alt ? 7'h20 : 7'h00, r.rs2, r.rs1, f3, r.rd, 7'b0110011};
         r.ap      = op_flags(f3, alt);
         r.legal   = 1'b1;
         r.use_rs1 = 1'b1;
         r.use_rs2 = 1'b1;
      end
   endtask

   //**********************************************************************
   // per-cycle stimulus and checks at the falling edge
   //**********************************************************************

   task automatic check_idle();
      assert (ifu_i0_ready == 1'b1)
         else report_mismatch("ifu_i0_ready", 32'(ifu_i0_ready), 32'd1);
      assert (dec_i0_decode_d == 1'b0)
         else report_mismatch("dec_i0_decode_d", 32'(dec_i0_decode_d), 32'd0);
      assert (dec_tlu_i0_valid_e4 == 1'b0)
         else report_mismatch("dec_tlu_i0_valid_e4", 32'(dec_tlu_i0_valid_e4), 32'd0);
      assert (trace_rv_trace_pkt.trace_rv_i_valid_ip == 1'b0)
         else report_mismatch("trace_rv_i_valid_ip",
                              32'(trace_rv_trace_pkt.trace_rv_i_valid_ip), 32'd0);
   endtask

   task automatic take_fetch();
      if (accepted) begin                    // transfer happened at the last edge
         decode_q.push_back(offer);
         sent++;
         if (sent < NUM_INSTR) begin
            build_instr(offer);
         end
      end
   endtask

   task automatic drive_execute();
      e4_exp_t x;
      if (dec_tlu_i0_valid_e4) begin
         assert (e4_q.size() != 0)
            else stop_on_error("an instruction reached e4 that was never decoded");
         x = e4_q.pop_front();
         assert ({dec_tlu_i0_pc_e4, 1'b0} == x.pc)
            else report_mismatch("dec_tlu_i0_pc_e4", {dec_tlu_i0_pc_e4, 1'b0}, x.pc);
         exu_i0_result_e4 = x.result;        // captured into wb at the next edge
      end else begin
         exu_i0_result_e4 = '0;
      end
   endtask

   task automatic check_trace();
      ref_instr_t e;
      logic [4:0] cause;
      if (trace_rv_trace_pkt.trace_rv_i_valid_ip) begin
         assert (trace_q.size() != 0)
            else stop_on_error("a trace packet came with no instruction outstanding");
         e     = trace_q.pop_front();
         cause = e.legal ? 5'd0 : 5'(`DEC_EXC_ILLEGAL);
         assert (trace_rv_trace_pkt.trace_rv_i_address_ip == e.pc)
            else report_mismatch("trace_rv_i_address_ip",
                                 trace_rv_trace_pkt.trace_rv_i_address_ip, e.pc);
         assert (trace_rv_trace_pkt.trace_rv_i_insn_ip == e.instr)
            else report_mismatch("trace_rv_i_insn_ip",
                                 trace_rv_trace_pkt.trace_rv_i_insn_ip, e.instr);
         assert (trace_rv_trace_pkt.trace_rv_i_exception_ip == !e.legal)
            else report_mismatch("trace_rv_i_exception_ip",
                                 32'(trace_rv_trace_pkt.trace_rv_i_exception_ip),
                                 32'(!e.legal));
         assert (trace_rv_trace_pkt.trace_rv_i_ecause_ip == cause)
            else report_mismatch("trace_rv_i_ecause_ip",
                                 32'(trace_rv_trace_pkt.trace_rv_i_ecause_ip), 32'(cause));
         retired++;
      end
   endtask

   task automatic check_decode();
      ref_instr_t  e;
      e4_exp_t     x;
      logic [31:0] a;
      logic [31:0] b;
      if (dec_i0_decode_d) begin
         assert (decode_q.size() != 0)
            else stop_on_error("decode fired with no instruction fetched");
         e = decode_q.pop_front();           // next in fetch order
         a = gpr_model[e.rs1];
         b = gpr_model[e.rs2];
         assert ({dec_i0_pc_d, 1'b0} == e.pc)
            else report_mismatch("dec_i0_pc_d", {dec_i0_pc_d, 1'b0}, e.pc);
         assert (i0_ap == e.ap)
            else report_mismatch("i0_ap", 32'(i0_ap), 32'(e.ap));
         assert (dec_i0_immed_d == e.imm)
            else report_mismatch("dec_i0_immed_d", dec_i0_immed_d, e.imm);
         if (e.use_rs1) begin
            assert (gpr_i0_rs1_d == a)
               else report_mismatch("gpr_i0_rs1_d", gpr_i0_rs1_d, a);
         end
         if (e.use_rs2) begin
            assert (gpr_i0_rs2_d == b)
               else report_mismatch("gpr_i0_rs2_d", gpr_i0_rs2_d, b);
         end
         x.pc     = e.pc;
         x.result = e.legal ? alu_model(e.ap, a, b, e.imm) : take_bits(32); // junk if illegal
         if (e.legal && (e.rd != 5'd0)) begin
            gpr_model[e.rd] = x.result;
         end
         e4_q.push_back(x);
         trace_q.push_back(e);
      end
   endtask

   task automatic drive_fetch();
      if (!ifu_i0_valid || accepted) begin   // a refused offer is held as is
         ifu_i0_valid = (sent < NUM_INSTR) && (take_bits(2) != 0);
      end
      ifu_i0_pkt.instr = offer.instr;
      ifu_i0_pkt.pc    = offer.pc[31:1];
      accepted         = ifu_i0_valid && ifu_i0_ready; // ready is steady until the edge
   endtask

   //**********************************************************************
   // run control
   //**********************************************************************

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      assert (cycle_cnt < TIMEOUT_CYCLES)
         else stop_on_error("timeout, not every instruction was traced in time");
   end

   initial begin
      clk              = 1'b0;
      reset            = 1'b1;
      ifu_i0_valid     = 1'b0;
      ifu_i0_pkt       = '0;
      exu_i0_result_e4 = '0;
      lfsr_state       = LFSR_SEED;
      next_pc          = PC_START;
      accepted         = 1'b0;
      sent             = 0;
      retired          = 0;
      cycle_cnt        = 0;
      for (int i = 0; i < 32; i++) begin
         gpr_model[i] = '0;                  // registers read zero after reset
      end
      repeat (RESET_CYCLES) @(negedge clk);
      reset = 1'b0;
      @(negedge clk);
      check_idle();
      build_instr(offer);
      while (retired < NUM_INSTR) begin
         take_fetch();
         drive_execute();
         check_trace();
         check_decode();
         drive_fetch();
         @(negedge clk);
      end
      $display("Done: no errors");
      $finish;
   end

endmodule

`default_nettype wire

// ==== dec.f ====
+incdir+hdl
hdl/dec_pkg.sv
hdl/dec_ib_ctl.sv
hdl/dec_decode_ctl.sv
hdl/dec_gpr_ctl.sv
hdl/dec_trace.sv
hdl/dec.sv
bench/dec_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the decode unit testbench with Verilator, runs it to sim.log and checks the log
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -f dec.f --top-module dec_tb -Mdir obj_dir -o dec_sim \
   > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/dec_sim > sim.log 2>&1
grep -q "Done: errors found" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "Done: no errors" sim.log || { echo "simulation did not complete, see sim.log"; exit 1; }
echo "simulation passed"
